/* design/profiler_pkg.sv */
`default_nettype none

package profiler_pkg;

  // Stall reasons, lower bit wins
  localparam int REASON_W      = 10;
  localparam int UNKNOWN_BIT   = 0;
  localparam int CMT_HAZ_BIT   = 1;
  localparam int EXCEPTION_BIT = 2;
  localparam int DIV_BUSY_BIT  = 3;
  localparam int RAW_HAZ_BIT   = 4;
  localparam int BR_HAZ_BIT    = 5;
  localparam int BR_MISS_BIT   = 6;
  localparam int BP_HAZ_BIT    = 7;
  localparam int IC_MISS_BIT   = 8;
  localparam int IQ_FULL_BIT   = 9;

  typedef logic [REASON_W-1:0] stall_vec_t;
  typedef logic [3:0]          reason_code_t;

  localparam int NUM_COMMIT_PORTS = 2;
  typedef logic [1:0] commit_cnt_t;

  // Counter index map
  localparam int IDX_MCYCLE       = 0;
  localparam int IDX_MINSTRET     = 1;
  localparam int IDX_STALL_BASE   = 2;
  localparam int IDX_EXTRA_CMT    = 12;
  localparam int IDX_BR_CNT       = 13;
  localparam int IDX_BR_MISS      = 14;
  localparam int IDX_JALR_CNT     = 15;
  localparam int IDX_JALR_MISS    = 16;
  localparam int IDX_RET_CNT      = 17;
  localparam int IDX_RET_MISS     = 18;
  localparam int IDX_IC_REQ       = 19;
  localparam int IDX_IC_MISS      = 20;
  localparam int IDX_IC_MISS_WAIT = 21;
  localparam int IDX_DIV_CNT      = 22;
  localparam int NUM_COUNTERS     = 23;

  // Resolved control-flow kind, code 3 unused
  typedef logic [1:0] branch_kind_t;
  localparam branch_kind_t KIND_BRANCH = 2'd0;
  localparam branch_kind_t KIND_JALR   = 2'd1;
  localparam branch_kind_t KIND_RET    = 2'd2;

endpackage

`default_nettype wire

/* design/frontend_stall_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module frontend_stall_tracker
  import profiler_pkg::*;
  (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       iq_ready_i,
    input  logic       ic_miss_i,
    input  logic       bp_valid_i,
    input  logic       iq_valid_i,
    input  logic       flush_i,
    input  logic       exception_i,
    output stall_vec_t id_vec_o
  );

  stall_vec_t pc_vec;
  stall_vec_t ic_vec;
  stall_vec_t id_vec;
  stall_vec_t pc_r;
  stall_vec_t ic_r;
  stall_vec_t id_r;

  always_comb begin
    // PC generation
    pc_vec = '0;
    pc_vec[IQ_FULL_BIT]   = ~iq_ready_i;
    pc_vec[IC_MISS_BIT]   = ic_miss_i;
    pc_vec[BR_MISS_BIT]   |= flush_i;
    pc_vec[EXCEPTION_BIT] |= exception_i;

    // A live miss replaces whatever came from PC gen
    ic_vec = pc_r;
    if (ic_miss_i) begin
      ic_vec = '0;
      ic_vec[IC_MISS_BIT] = 1'b1;
    end
    ic_vec[BP_HAZ_BIT]    |= bp_valid_i;
    ic_vec[BR_MISS_BIT]   |= flush_i;
    ic_vec[EXCEPTION_BIT] |= exception_i;

    // Valid queue output means decode is not starved
    id_vec = iq_valid_i ? '0 : ic_r;
    id_vec[BR_MISS_BIT]   |= flush_i;
    id_vec[EXCEPTION_BIT] |= exception_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r <= '0;
      ic_r <= '0;
      id_r <= '0;
    end else begin
      pc_r <= pc_vec;
      ic_r <= ic_vec;
      id_r <= id_vec;
    end
  end

  assign id_vec_o = id_r;

endmodule

`default_nettype wire

/* design/issue_stall_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_stall_classifier
  import profiler_pkg::*;
  (
    input  stall_vec_t                  id_vec_i,
    input  logic                        is_valid_i,
    input  logic                        is_ack_i,
    input  logic                        is_unresolved_branch_i,
    input  logic                        is_raw_i,
    input  logic                        div_busy_i,
    input  logic                        sb_full_i,
    input  logic                        cmt_valid_i,
    input  logic [NUM_COMMIT_PORTS-1:0] cmt_ack_i,
    input  logic                        flush_i,
    input  logic                        exception_i,
    output stall_vec_t                  is_vec_o,
    output logic                        stall_o
  );

  logic issue_stalled;
  logic cmt_blocked;

  // Valid instruction sitting at issue without an acknowledge
  assign issue_stalled = is_valid_i & ~is_ack_i;

  // Scoreboard full because the head entry is not retiring
  assign cmt_blocked = sb_full_i & cmt_valid_i & ~cmt_ack_i[0];

  always_comb begin
    is_vec_o = id_vec_i;

    is_vec_o[BR_HAZ_BIT]   |= issue_stalled & is_unresolved_branch_i;
    is_vec_o[RAW_HAZ_BIT]  |= issue_stalled & is_raw_i;
    is_vec_o[DIV_BUSY_BIT] |= issue_stalled & div_busy_i;
    is_vec_o[CMT_HAZ_BIT]  |= issue_stalled & cmt_blocked;

    // Flushes are charged whether or not issue holds an instruction
    is_vec_o[BR_MISS_BIT]   |= flush_i;
    is_vec_o[EXCEPTION_BIT] |= exception_i;
  end

  // Any cycle without an issue acknowledge is a lost slot
  assign stall_o = ~is_ack_i;

endmodule

`default_nettype wire

/* design/stall_priority_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module stall_priority_encoder
  import profiler_pkg::*;
  (
    input  stall_vec_t          is_vec_i,
    input  logic                stall_i,
    output logic [REASON_W-1:0] stall_en_o
  );

  reason_code_t reason;

  // Lowest set bit, unknown when nothing is set
  always_comb begin
    reason = reason_code_t'(UNKNOWN_BIT);
    for (int i = REASON_W - 1; i >= 0; i--) begin
      if (is_vec_i[i]) begin
        reason = reason_code_t'(i);
      end
    end
  end

  // One-hot charge of the winning reason
  always_comb begin
    stall_en_o = '0;
    if (stall_i) begin
      stall_en_o[reason] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/event_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module event_monitor
  import profiler_pkg::*;
  (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     br_valid_i,
    input  branch_kind_t                             br_kind_i,
    input  logic                                     br_mispredict_i,
    input  logic [NUM_COMMIT_PORTS-1:0]              cmt_ack_i,
    input  logic                                     ic_resp_valid_i,
    input  logic                                     ic_miss_i,
    input  logic                                     div_valid_i,
    output logic [NUM_COUNTERS-IDX_EXTRA_CMT-1:0]    event_en_o
  );

  logic is_br;
  logic is_jalr;
  logic is_ret;
  logic ic_miss_pending_r;

  assign is_br   = br_valid_i & (br_kind_i == KIND_BRANCH);
  assign is_jalr = br_valid_i & (br_kind_i == KIND_JALR);
  assign is_ret  = br_valid_i & (br_kind_i == KIND_RET);

  // Miss outstanding until the refill response, a new miss takes priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ic_miss_pending_r <= 1'b0;
    end else if (ic_miss_i) begin
      ic_miss_pending_r <= 1'b1;
    end else if (ic_resp_valid_i) begin
      ic_miss_pending_r <= 1'b0;
    end
  end

  // Bit k maps to counter IDX_EXTRA_CMT + k
  always_comb begin
    event_en_o = '0;
    event_en_o[IDX_EXTRA_CMT - IDX_EXTRA_CMT]    = cmt_ack_i[1];
    event_en_o[IDX_BR_CNT - IDX_EXTRA_CMT]       = is_br;
    event_en_o[IDX_BR_MISS - IDX_EXTRA_CMT]      = is_br & br_mispredict_i;
    event_en_o[IDX_JALR_CNT - IDX_EXTRA_CMT]     = is_jalr;
    event_en_o[IDX_JALR_MISS - IDX_EXTRA_CMT]    = is_jalr & br_mispredict_i;
    event_en_o[IDX_RET_CNT - IDX_EXTRA_CMT]      = is_ret;
    event_en_o[IDX_RET_MISS - IDX_EXTRA_CMT]     = is_ret & br_mispredict_i;
    event_en_o[IDX_IC_REQ - IDX_EXTRA_CMT]       = ic_resp_valid_i;
    event_en_o[IDX_IC_MISS - IDX_EXTRA_CMT]      = ic_miss_i;
    event_en_o[IDX_IC_MISS_WAIT - IDX_EXTRA_CMT] = ic_miss_pending_r;
    event_en_o[IDX_DIV_CNT - IDX_EXTRA_CMT]      = div_valid_i;
  end

endmodule

`default_nettype wire

/* design/counter_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module counter_bank
  import profiler_pkg::*;
  #(parameter int width_p = 32)
  (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  en_i,
    input  logic [NUM_COUNTERS-1:0]               inc_i,
    input  commit_cnt_t                           step_i,
    output logic [NUM_COUNTERS-1:0][width_p-1:0] data_o
  );

  logic [NUM_COUNTERS-1:0][width_p-1:0] step;

  // minstret may retire several per cycle, the rest step by one
  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      step[i] = (i == IDX_MINSTRET) ? width_p'(step_i) : width_p'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_o <= '0;
    end else if (en_i) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (inc_i[i]) begin
          data_o[i] <= data_o[i] + step[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/profiler_top.sv */
`timescale 1ns/1ns
`default_nettype none

module profiler_top
  import profiler_pkg::*;
  #(parameter int width_p = 32)
  (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  en_i,

    input  logic                                  iq_ready_i,
    input  logic                                  ic_miss_i,
    input  logic                                  bp_valid_i,
    input  logic                                  iq_valid_i,
    input  logic                                  flush_i,
    input  logic                                  exception_i,

    input  logic                                  is_valid_i,
    input  logic                                  is_ack_i,
    input  logic                                  is_unresolved_branch_i,
    input  logic                                  is_raw_i,
    input  logic                                  div_busy_i,
    input  logic                                  sb_full_i,
    input  logic                                  cmt_valid_i,
    input  logic [NUM_COMMIT_PORTS-1:0]           cmt_ack_i,

    input  logic                                  br_valid_i,
    input  branch_kind_t                          br_kind_i,
    input  logic                                  br_mispredict_i,
    input  logic                                  ic_resp_valid_i,
    input  logic                                  div_valid_i,

    output logic [NUM_COUNTERS-1:0][width_p-1:0] data_o
  );

  stall_vec_t                           id_vec;
  stall_vec_t                           is_vec;
  logic                                 stall;
  logic [REASON_W-1:0]                  stall_en;
  logic [NUM_COUNTERS-IDX_EXTRA_CMT-1:0] event_en;
  logic [NUM_COUNTERS-1:0]              inc;
  commit_cnt_t                          commit_step;

  frontend_stall_tracker frontend_stall_tracker_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .iq_ready_i  (iq_ready_i),
    .ic_miss_i   (ic_miss_i),
    .bp_valid_i  (bp_valid_i),
    .iq_valid_i  (iq_valid_i),
    .flush_i     (flush_i),
    .exception_i (exception_i),
    .id_vec_o    (id_vec)
  );

  issue_stall_classifier issue_stall_classifier_inst (
    .id_vec_i               (id_vec),
    .is_valid_i             (is_valid_i),
    .is_ack_i               (is_ack_i),
    .is_unresolved_branch_i (is_unresolved_branch_i),
    .is_raw_i               (is_raw_i),
    .div_busy_i             (div_busy_i),
    .sb_full_i              (sb_full_i),
    .cmt_valid_i            (cmt_valid_i),
    .cmt_ack_i              (cmt_ack_i),
    .flush_i                (flush_i),
    .exception_i            (exception_i),
    .is_vec_o               (is_vec),
    .stall_o                (stall)
  );

  stall_priority_encoder stall_priority_encoder_inst (
    .is_vec_i   (is_vec),
    .stall_i    (stall),
    .stall_en_o (stall_en)
  );

  event_monitor event_monitor_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .br_valid_i      (br_valid_i),
    .br_kind_i       (br_kind_i),
    .br_mispredict_i (br_mispredict_i),
    .cmt_ack_i       (cmt_ack_i),
    .ic_resp_valid_i (ic_resp_valid_i),
    .ic_miss_i       (ic_miss_i),
    .div_valid_i     (div_valid_i),
    .event_en_o      (event_en)
  );

  // Retired instructions this cycle
  always_comb begin
    commit_step = '0;
    for (int i = 0; i < NUM_COMMIT_PORTS; i++) begin
      commit_step = commit_step + commit_cnt_t'(cmt_ack_i[i]);
    end
  end

  always_comb begin
    inc = '0;
    inc[IDX_MCYCLE]   = 1'b1;
    inc[IDX_MINSTRET] = |cmt_ack_i;
    inc[IDX_STALL_BASE +: REASON_W] = stall_en;
    inc[IDX_EXTRA_CMT +: NUM_COUNTERS-IDX_EXTRA_CMT] = event_en;
  end

  counter_bank #(.width_p(width_p)) counter_bank_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en_i),
    .inc_i   (inc),
    .step_i  (commit_step),
    .data_o  (data_o)
  );

endmodule

`default_nettype wire

/* tests/profiler_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module profiler_checker
  import profiler_pkg::*;
  #(parameter int width_p = 32)
  (
    input logic                                  clk_i,
    input logic                                  reset_i,
    input logic                                  en_i,
    input logic                                  stall_i,
    input logic [REASON_W-1:0]                   stall_en_i,
    input logic [NUM_COUNTERS-1:0][width_p-1:0] data_i
  );

  assert property (@(posedge clk_i) reset_i |=> (data_i == '0))
    else $error("Counters are not zero after reset");

  // Disabled profiler freezes every count
  assert property (@(posedge clk_i) disable iff (reset_i) !en_i |=> $stable(data_i))
    else $error("A counter changed while the profiler was disabled");

  assert property (@(posedge clk_i) disable iff (reset_i)
    en_i |=> (data_i[IDX_MCYCLE] == $past(data_i[IDX_MCYCLE]) + width_p'(1)))
    else $error("Cycle counter did not advance by one");

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(stall_en_i))
    else $error("More than one stall reason charged in a cycle");

  assert property (@(posedge clk_i) disable iff (reset_i) !stall_i |-> (stall_en_i == '0))
    else $error("Stall reason charged without a stall");

endmodule

bind profiler_top profiler_checker #(.width_p(width_p)) profiler_checker_inst (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .en_i       (en_i),
  .stall_i    (stall),
  .stall_en_i (stall_en),
  .data_i     (data_o)
);

`default_nettype wire

/* tests/profiler_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module profiler_tb
  import profiler_pkg::*;
  ();

  localparam int WIDTH          = 32;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 2;

  // Per-counter increment for one cycle, minstret can step by 2
  typedef logic [NUM_COUNTERS-1:0][1:0] incr_t;

  logic clk;
  logic reset;
  logic en;
  logic iq_ready;
  logic ic_miss;
  logic bp_valid;
  logic iq_valid;
  logic flush;
  logic exception;
  logic is_valid;
  logic is_ack;
  logic is_unresolved_branch;
  logic is_raw;
  logic div_busy;
  logic sb_full;
  logic cmt_valid;
  logic [NUM_COMMIT_PORTS-1:0] cmt_ack;
  logic br_valid;
  branch_kind_t br_kind;
  logic br_mispredict;
  logic ic_resp_valid;
  logic div_valid;
  logic [NUM_COUNTERS-1:0][WIDTH-1:0] data_o;

  // Reference model state
  stall_vec_t pc_q;
  stall_vec_t ic_q;
  stall_vec_t id_q;
  logic miss_pending_q;
  logic [WIDTH-1:0] model_count [NUM_COUNTERS];

  int seed;
  int cycle_count;

  profiler_top #(.width_p(WIDTH)) profiler_top_inst (
    .clk_i                  (clk),
    .reset_i                (reset),
    .en_i                   (en),
    .iq_ready_i             (iq_ready),
    .ic_miss_i              (ic_miss),
    .bp_valid_i             (bp_valid),
    .iq_valid_i             (iq_valid),
    .flush_i                (flush),
    .exception_i            (exception),
    .is_valid_i             (is_valid),
    .is_ack_i               (is_ack),
    .is_unresolved_branch_i (is_unresolved_branch),
    .is_raw_i               (is_raw),
    .div_busy_i             (div_busy),
    .sb_full_i              (sb_full),
    .cmt_valid_i            (cmt_valid),
    .cmt_ack_i              (cmt_ack),
    .br_valid_i             (br_valid),
    .br_kind_i              (br_kind),
    .br_mispredict_i        (br_mispredict),
    .ic_resp_valid_i        (ic_resp_valid),
    .div_valid_i            (div_valid),
    .data_o                 (data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic chance_one_in(input int n);
    int r;
    r = $random(seed);
    return ((r & 32'h7fff_ffff) % n) == 0;
  endfunction

  function automatic stall_vec_t add_flush_bits(input stall_vec_t vec);
    stall_vec_t v;
    v = vec;
    if (flush) v[BR_MISS_BIT] = 1'b1;
    if (exception) v[EXCEPTION_BIT] = 1'b1;
    return v;
  endfunction

  // Expected counter steps from the decode-stage vector and current inputs
  function automatic incr_t expected_increments(input stall_vec_t id_r, input logic pending);
    incr_t inc;
    stall_vec_t vec;
    logic hold;
    logic found;
    int winner;
    inc = '0;
    inc[IDX_MCYCLE]   = 2'd1;
    inc[IDX_MINSTRET] = 2'(cmt_ack[0]) + 2'(cmt_ack[1]);
    hold = is_valid && !is_ack;
    vec = id_r;
    if (hold && is_unresolved_branch) vec[BR_HAZ_BIT] = 1'b1;
    if (hold && is_raw) vec[RAW_HAZ_BIT] = 1'b1;
    if (hold && div_busy) vec[DIV_BUSY_BIT] = 1'b1;
    if (hold && sb_full && cmt_valid && !cmt_ack[0]) vec[CMT_HAZ_BIT] = 1'b1;
    vec = add_flush_bits(vec);
    if (!is_ack) begin
      winner = UNKNOWN_BIT;
      found = 1'b0;
      for (int b = 0; b < REASON_W; b++) begin
        if (vec[b] && !found) begin
          winner = b;
          found = 1'b1;
        end
      end
      inc[IDX_STALL_BASE + winner] = 2'd1;
    end
    inc[IDX_EXTRA_CMT] = 2'(cmt_ack[1]);
    if (br_valid) begin
      case (br_kind)
        KIND_BRANCH: begin
          inc[IDX_BR_CNT]  = 2'd1;
          inc[IDX_BR_MISS] = 2'(br_mispredict);
        end
        KIND_JALR: begin
          inc[IDX_JALR_CNT]  = 2'd1;
          inc[IDX_JALR_MISS] = 2'(br_mispredict);
        end
        KIND_RET: begin
          inc[IDX_RET_CNT]  = 2'd1;
          inc[IDX_RET_MISS] = 2'(br_mispredict);
        end
        default: begin
        end
      endcase
    end
    inc[IDX_IC_REQ]       = 2'(ic_resp_valid);
    inc[IDX_IC_MISS]      = 2'(ic_miss);
    inc[IDX_IC_MISS_WAIT] = 2'(pending);
    inc[IDX_DIV_CNT]      = 2'(div_valid);
    return inc;
  endfunction

  // Shift the model's front-end stages by one clock
  task automatic advance_frontend();
    stall_vec_t pc_n;
    stall_vec_t ic_n;
    stall_vec_t id_n;
    pc_n = '0;
    if (!iq_ready) pc_n[IQ_FULL_BIT] = 1'b1;
    if (ic_miss) pc_n[IC_MISS_BIT] = 1'b1;
    if (ic_miss) begin
      ic_n = '0;
      ic_n[IC_MISS_BIT] = 1'b1;
    end else begin
      ic_n = pc_q;
    end
    if (bp_valid) ic_n[BP_HAZ_BIT] = 1'b1;
    id_n = iq_valid ? '0 : ic_q;
    pc_q = add_flush_bits(pc_n);
    ic_q = add_flush_bits(ic_n);
    id_q = add_flush_bits(id_n);
    if (ic_miss) miss_pending_q = 1'b1;
    else if (ic_resp_valid) miss_pending_q = 1'b0;
  endtask

  task automatic check_value(input int idx, input logic [WIDTH-1:0] actual,
                             input logic [WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: counter %0d is %0d, expected %0d",
               $time, idx, actual, expected);
      $display("Test FAILED");
      $fatal(1, "Counter mismatch");
    end
  endtask

  // Hazards are rare in the first half so front-end causes win more often
  task automatic drive_random_inputs(input int n);
    int hz;
    hz = (n < NUM_CYCLES / 2) ? 16 : 4;
    en                   = !chance_one_in(16);
    iq_ready             = !chance_one_in(4);
    ic_miss              = chance_one_in(12);
    bp_valid             = chance_one_in(8);
    iq_valid             = chance_one_in(3);
    flush                = chance_one_in(24);
    exception            = chance_one_in(40);
    is_valid             = !chance_one_in(5);
    is_ack               = chance_one_in(2);
    is_unresolved_branch = chance_one_in(hz);
    is_raw               = chance_one_in(hz);
    div_busy             = chance_one_in(hz);
    sb_full              = chance_one_in(hz / 2);
    cmt_valid            = chance_one_in(2);
    cmt_ack              = 2'($random(seed));
    br_valid             = chance_one_in(3);
    br_kind              = 2'($random(seed));
    br_mispredict        = chance_one_in(3);
    ic_resp_valid        = chance_one_in(10);
    div_valid            = chance_one_in(12);
  endtask

  // Compare on the falling edge, then advance the model
  initial begin : compare_proc
    incr_t inc;
    forever begin
      @(negedge clk);
      if (reset) begin
        pc_q = '0;
        ic_q = '0;
        id_q = '0;
        miss_pending_q = 1'b0;
        for (int i = 0; i < NUM_COUNTERS; i++) model_count[i] = '0;
      end else begin
        for (int i = 0; i < NUM_COUNTERS; i++) check_value(i, data_o[i], model_count[i]);
        inc = expected_increments(id_q, miss_pending_q);
        if (en) begin
          for (int i = 0; i < NUM_COUNTERS; i++) begin
            model_count[i] = model_count[i] + WIDTH'(inc[i]);
          end
        end
        advance_frontend();
      end
    end
  end

  initial begin : timeout_watch
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "Timeout");
  end

  initial begin : stimulus
    seed = 13;
    reset = 1'b1;
    en = 1'b0;
    iq_ready = 1'b1;
    ic_miss = 1'b0;
    bp_valid = 1'b0;
    iq_valid = 1'b0;
    flush = 1'b0;
    exception = 1'b0;
    is_valid = 1'b0;
    is_ack = 1'b1;
    is_unresolved_branch = 1'b0;
    is_raw = 1'b0;
    div_busy = 1'b0;
    sb_full = 1'b0;
    cmt_valid = 1'b0;
    cmt_ack = '0;
    br_valid = 1'b0;
    br_kind = KIND_BRANCH;
    br_mispredict = 1'b0;
    ic_resp_valid = 1'b0;
    div_valid = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_random_inputs(n);
      @(posedge clk);
      #1;
    end
    // Let the last compare run
    repeat (2) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/profiler_pkg.sv
design/frontend_stall_tracker.sv
design/issue_stall_classifier.sv
design/stall_priority_encoder.sv
design/event_monitor.sv
design/counter_bank.sv
design/profiler_top.sv
tests/profiler_checker.sv
tests/profiler_tb.sv

/* Makefile */
TOP = profiler_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP)

build:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
